//--- organ_top.f
src/organ_pkg.sv
src/key_event_gen.sv
src/speed_register.sv
src/hex_display.sv
src/tone_gen.sv
src/sample_port.sv
src/organ_top.sv
verif/organ_assertions.sv
verif/organ_tb.sv

//--- verif/organ_tb.sv
`timescale 1ns/1ps
`default_nettype none

module organ_tb import organ_pkg::*; ();

  localparam int CLK_HZ          = 20_000;
  localparam int EVENT_INTERVAL  = 16;
  localparam int SPEED_STEP      = 100;
  localparam int DEFAULT_COUNT   = 12499;
  localparam int DISPLAY_REFRESH = 8;

  localparam int RESET_CYCLES   = 10;
  localparam int ACK_DELAY_MAX  = 5;
  localparam int HALF_TOLERANCE = ACK_DELAY_MAX + 4;
  localparam int DISPLAY_WAIT   = EVENT_INTERVAL + 2 + DISPLAY_REFRESH + 2 + 4;

  // Key phases in events; the floor run needs 123 steps down to 199
  localparam int UP_EVENTS    = 4;
  localparam int DOWN_EVENTS  = 6;
  localparam int BOTH_EVENTS  = 3;
  localparam int FLOOR_EVENTS = 126;
  localparam int KEY_EVENTS   = UP_EVENTS + DOWN_EVENTS + BOTH_EVENTS + FLOOR_EVENTS + 1;
  localparam int KEY_PHASES   = 5;

  localparam int NOTE_HZ [8] = '{262, 294, 330, 349, 392, 440, 494, 523};
  localparam int LONGEST_HALF    = CLK_HZ / (2 * 262);
  localparam int NOTE_CHANGES    = 6;
  localparam int NOTES_MEASURED  = 3;
  localparam int TONE_OFF_CYCLES = 100;

  localparam int WATCHDOG_CYCLES = 2 * (RESET_CYCLES + KEY_EVENTS * DISPLAY_WAIT
    + KEY_PHASES * (EVENT_INTERVAL + 4) + TONE_OFF_CYCLES
    + NOTES_MEASURED * (NOTE_CHANGES + 3) * (LONGEST_HALF + HALF_TOLERANCE) + 100);

  logic      CLK_50M = 1'b0;
  logic      arst_n;
  logic      key_up_n;
  logic      key_down_n;
  logic      key_reset_n;
  note_sel_t note_sel;
  logic      tone_on;
  logic      sample_ack;
  logic      sample_req;
  sample_t   sample_data;
  seg_t      hex0;
  seg_t      hex1;
  seg_t      hex2;
  seg_t      hex3;

  int      model_count;
  int      cycle;
  int      change_cyc[$];
  sample_t last_accepted;
  logic    have_accepted;

  organ_top #(
    .CLK_HZ          (CLK_HZ),
    .EVENT_INTERVAL  (EVENT_INTERVAL),
    .SPEED_STEP      (SPEED_STEP),
    .DEFAULT_COUNT   (DEFAULT_COUNT),
    .DISPLAY_REFRESH (DISPLAY_REFRESH)
  ) i_dut (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .key_up_n    (key_up_n),
    .key_down_n  (key_down_n),
    .key_reset_n (key_reset_n),
    .note_sel    (note_sel),
    .tone_on     (tone_on),
    .sample_ack  (sample_ack),
    .sample_req  (sample_req),
    .sample_data (sample_data),
    .hex0        (hex0),
    .hex1        (hex1),
    .hex2        (hex2),
    .hex3        (hex3)
  );

  always #10 CLK_50M = ~CLK_50M;

  always @(posedge CLK_50M)
  begin
    cycle <= cycle + 1;
  end

  // ==========================================================
  // Reference rules
  // ==========================================================
  function automatic seg_t digit_segments(input logic [3:0] nibble);
    case (nibble)
      4'h0: return 7'h40;
      4'h1: return 7'h79;
      4'h2: return 7'h24;
      4'h3: return 7'h30;
      4'h4: return 7'h19;
      4'h5: return 7'h12;
      4'h6: return 7'h02;
      4'h7: return 7'h78;
      4'h8: return 7'h00;
      4'h9: return 7'h10;
      4'hA: return 7'h08;
      4'hB: return 7'h03;
      4'hC: return 7'h46;
      4'hD: return 7'h21;
      4'hE: return 7'h06;
      default: return 7'h0E;
    endcase
  endfunction

  // hex3 down to hex0
  function automatic logic [27:0] count_segments(input int value);
    return {digit_segments(4'(value >> 12)), digit_segments(4'(value >> 8)),
            digit_segments(4'(value >> 4)), digit_segments(4'(value))};
  endfunction

  function automatic int next_count(input int value, input logic up, input logic down);
    if (up && !down && value + SPEED_STEP <= 16'hFFFF)
      return value + SPEED_STEP;
    if (down && !up && value - SPEED_STEP >= SPEED_STEP)
      return value - SPEED_STEP;
    return value;
  endfunction

  function automatic int half_period(input int note);
    return CLK_HZ / (2 * NOTE_HZ[note]);
  endfunction

  // ==========================================================
  // Checks and key sequences
  // ==========================================================
  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Verification failed");
    $fatal(1, "Stopped at the first failing check");
  endtask

  task automatic check_display(input int expected);
    logic [27:0] shown;
    shown = {hex3, hex2, hex1, hex0};
    if (shown !== count_segments(expected))
      stop_with_failure($sformatf(
        "Mismatch at %0t: hex3..hex0 expected %07h (count %0d), got %07h",
        $time, count_segments(expected), expected, shown));
  endtask

  task automatic wait_for_display(input int expected);
    int          waited;
    logic [27:0] shown;
    waited = 0;
    shown  = {hex3, hex2, hex1, hex0};
    while (shown !== count_segments(expected))
    begin
      // Only the old count may show until the new one arrives
      if (shown !== count_segments(model_count) || waited >= DISPLAY_WAIT)
        stop_with_failure($sformatf(
          "Mismatch at %0t: hex3..hex0 expected %07h (count %0d), got %07h",
          $time, count_segments(expected), expected, shown));
      @(negedge CLK_50M);
      waited++;
      shown = {hex3, hex2, hex1, hex0};
    end
  endtask

  task automatic settle_display();
    repeat (EVENT_INTERVAL + 4)
    begin
      @(negedge CLK_50M);
      check_display(model_count);
    end
  endtask

  task automatic hold_keys(input logic up, input logic down, input int events);
    int next;
    key_up_n   = !up;
    key_down_n = !down;
    for (int i = 0; i < events; i++)
    begin
      next = next_count(model_count, up, down);
      if (next != model_count)
      begin
        wait_for_display(next);
        model_count = next;
      end
      else
      begin
        // Ignored event leaves the display unchanged for a whole interval
        repeat (EVENT_INTERVAL)
        begin
          @(negedge CLK_50M);
          check_display(model_count);
        end
      end
    end
    key_up_n   = 1'b1;
    key_down_n = 1'b1;
    settle_display();
  endtask

  task automatic press_reset_key();
    key_reset_n = 1'b0;
    wait_for_display(DEFAULT_COUNT);
    model_count = DEFAULT_COUNT;
    key_reset_n = 1'b1;
    settle_display();
  endtask

  task automatic measure_note(input int note);
    int half;
    int waited;
    int gap;
    half     = half_period(note);
    note_sel = note_sel_t'(note);
    tone_on  = 1'b1;
    repeat (2 * half) @(negedge CLK_50M);
    change_cyc.delete();
    waited = 0;
    while (change_cyc.size() < NOTE_CHANGES)
    begin
      if (waited > (NOTE_CHANGES + 1) * (half + HALF_TOLERANCE))
        stop_with_failure($sformatf("No sample changes reached the sink for note %0d", note));
      @(negedge CLK_50M);
      waited++;
    end
    for (int i = 1; i < NOTE_CHANGES; i++)
    begin
      gap = change_cyc[i] - change_cyc[i-1];
      if (gap < half - HALF_TOLERANCE || gap > half + HALF_TOLERANCE)
        stop_with_failure($sformatf(
          "Mismatch at %0t: sample_data half period note %0d expected %0d +/- %0d, got %0d",
          $time, note, half, HALF_TOLERANCE, gap));
    end
  endtask

  // ==========================================================
  // Audio sink with random ack delay
  // ==========================================================
  initial
  begin
    int offer_cycle;
    void'($urandom(32'h877f));
    sample_ack = 1'b0;
    forever
    begin
      @(negedge CLK_50M);
      if (sample_req && !sample_ack)
      begin
        offer_cycle = cycle;
        repeat ($urandom % (ACK_DELAY_MAX + 1)) @(negedge CLK_50M);
        sample_ack = 1'b1;
        if (have_accepted && sample_data != last_accepted)
          change_cyc.push_back(offer_cycle);
        last_accepted = sample_data;
        have_accepted = 1'b1;
        while (sample_req) @(negedge CLK_50M);
        sample_ack = 1'b0;
      end
    end
  end

  // Bound checker counts its own failures
  always @(negedge CLK_50M)
  begin
    if (i_dut.i_assertions.fail_count != 0)
      stop_with_failure("A concurrent assertion in the bound checker failed");
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK_50M);
    stop_with_failure($sformatf("Watchdog expired after %0d cycles, the run did not finish",
      WATCHDOG_CYCLES));
  end

  // ==========================================================
  // Main sequence
  // ==========================================================
  initial
  begin
    arst_n        = 1'b0;
    key_up_n      = 1'b1;
    key_down_n    = 1'b1;
    key_reset_n   = 1'b1;
    note_sel      = '0;
    tone_on       = 1'b0;
    cycle         = 0;
    have_accepted = 1'b0;
    model_count   = DEFAULT_COUNT;
    repeat (RESET_CYCLES) @(negedge CLK_50M);
    if (sample_req !== 1'b0)
      stop_with_failure($sformatf("Mismatch at %0t: sample_req expected 0, got %b",
        $time, sample_req));
    check_display(model_count);
    arst_n = 1'b1;

    // Up, down, reset key, both keys, then down to the floor
    hold_keys(1'b1, 1'b0, UP_EVENTS);
    hold_keys(1'b0, 1'b1, DOWN_EVENTS);
    press_reset_key();
    hold_keys(1'b1, 1'b1, BOTH_EVENTS);
    hold_keys(1'b0, 1'b1, FLOOR_EVENTS);

    repeat (TONE_OFF_CYCLES) @(negedge CLK_50M);
    measure_note(0);
    measure_note(3);
    measure_note(7);
    tone_on = 1'b0;
    repeat (50) @(negedge CLK_50M);

    if (i_dut.i_assertions.fail_count == 0)
    begin
      $display("Verification passed");
      $finish;
    end
    else
    begin
      stop_with_failure("A concurrent assertion failed before the end of the run");
    end
  end

endmodule

`default_nettype wire

//--- verif/organ_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module organ_assertions import organ_pkg::*; (
  input wire logic    CLK_50M,
  input wire logic    arst_n,
  input wire logic    tone_on,
  input wire logic    sample_ack,
  input wire logic    sample_req,
  input wire sample_t sample_data
);

  // Square wave levels as seen by the sink
  localparam sample_t TONE_HIGH = sample_t'(127);
  localparam sample_t TONE_LOW  = sample_t'(-128);

  int unsigned fail_count = 0;
  logic        tone_at_capture;

  task automatic record_failure(input string msg);
    fail_count++;
    $error("%s", msg);
  endtask

  // tone_on as it was on the edge that loaded sample_data
  always_ff @(posedge CLK_50M)
  begin
    if (!sample_req)
      tone_at_capture <= tone_on;
  end

  // ==========================================================
  // Four-phase handshake
  // ==========================================================
  a_req_low_in_reset: assert property (@(posedge CLK_50M) !arst_n |-> !sample_req)
    else record_failure("sample_req high during reset");

  a_req_rise: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    $rose(sample_req) |-> !$past(sample_ack))
    else record_failure("sample_req rose while sample_ack was high");

  a_data_stable: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    sample_req && $past(sample_req) |-> $stable(sample_data))
    else record_failure("sample_data changed during an offer");

  a_req_fall: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    $fell(sample_req) |-> $past(sample_ack))
    else record_failure("sample_req fell before sample_ack was seen high");

  // No new offer until the previous ack is gone
  a_wait_ack_low: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    sample_ack && !sample_req |=> !sample_req)
    else record_failure("sample_req rose before sample_ack went low");

  // ==========================================================
  // Accepted sample values
  // ==========================================================
  a_tone_levels: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    sample_req && sample_ack && tone_at_capture |->
      (sample_data == TONE_HIGH) || (sample_data == TONE_LOW))
    else record_failure("accepted tone sample is not a full-scale level");

  a_muted: assert property (@(posedge CLK_50M) disable iff (!arst_n)
    sample_req && sample_ack && !tone_at_capture |-> sample_data == '0)
    else record_failure("accepted sample not zero while muted");

endmodule

bind organ_top organ_assertions i_assertions (
  .CLK_50M     (CLK_50M),
  .arst_n      (arst_n),
  .tone_on     (tone_on),
  .sample_ack  (sample_ack),
  .sample_req  (sample_req),
  .sample_data (sample_data)
);

`default_nettype wire

//--- src/organ_top.sv
`timescale 1ns/1ps
`default_nettype none

module organ_top import organ_pkg::*; #(
  parameter int CLK_HZ          = 50_000_000,
  parameter int EVENT_INTERVAL  = 100_000,
  parameter int SPEED_STEP      = 100,
  parameter int DEFAULT_COUNT   = 12499,
  parameter int DISPLAY_REFRESH = 25_000_000
) (
  input  wire logic      CLK_50M,
  input  wire logic      arst_n,
  input  wire logic      key_up_n,
  input  wire logic      key_down_n,
  input  wire logic      key_reset_n,
  input  wire note_sel_t note_sel,
  input  wire logic      tone_on,
  input  wire logic      sample_ack,
  output logic           sample_req,
  output sample_t        sample_data,
  output seg_t           hex0,
  output seg_t           hex1,
  output seg_t           hex2,
  output seg_t           hex3
);

  logic    up_event;
  logic    down_event;
  logic    reset_level;
  count_t  count;
  sample_t sample;

  // ==========================================================
  // Key path to the display
  // ==========================================================
  key_event_gen #(
    .EVENT_INTERVAL (EVENT_INTERVAL)
  ) i_key_event_gen (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .key_up_n    (key_up_n),
    .key_down_n  (key_down_n),
    .key_reset_n (key_reset_n),
    .up_event    (up_event),
    .down_event  (down_event),
    .reset_level (reset_level)
  );

  speed_register #(
    .SPEED_STEP    (SPEED_STEP),
    .DEFAULT_COUNT (DEFAULT_COUNT)
  ) i_speed_register (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .up_event    (up_event),
    .down_event  (down_event),
    .reset_level (reset_level),
    .count       (count)
  );

  hex_display #(
    .DISPLAY_REFRESH (DISPLAY_REFRESH)
  ) i_hex_display (
    .CLK_50M (CLK_50M),
    .arst_n  (arst_n),
    .count   (count),
    .hex0    (hex0),
    .hex1    (hex1),
    .hex2    (hex2),
    .hex3    (hex3)
  );

  // ==========================================================
  // Tone path to the audio sink
  // ==========================================================
  tone_gen #(
    .CLK_HZ (CLK_HZ)
  ) i_tone_gen (
    .CLK_50M  (CLK_50M),
    .arst_n   (arst_n),
    .note_sel (note_sel),
    .tone_on  (tone_on),
    .sample   (sample)
  );

  sample_port i_sample_port (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .sample      (sample),
    .sample_ack  (sample_ack),
    .sample_req  (sample_req),
    .sample_data (sample_data)
  );

endmodule

`default_nettype wire

//--- src/sample_port.sv
`timescale 1ns/1ps
`default_nettype none

module sample_port import organ_pkg::*; (
  input  wire logic    CLK_50M,
  input  wire logic    arst_n,
  input  wire sample_t sample,
  input  wire logic    sample_ack,
  output logic         sample_req,
  output sample_t      sample_data
);

  port_state_t state;
  port_state_t state_next;
  logic        capture;

  // ==========================================================
  // Four-phase handshake FSM
  // ==========================================================
  always_comb
  begin
    state_next = state;
    capture    = 1'b0;
    case (state)
      IDLE:
      begin
        // Previous ack must be low before a new offer
        if (!sample_ack)
        begin
          capture    = 1'b1;
          state_next = OFFER;
        end
      end
      OFFER:
      begin
        if (sample_ack)
          state_next = RELEASE;
      end
      RELEASE:
      begin
        if (!sample_ack)
          state_next = IDLE;
      end
      default:
      begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      state <= IDLE;
    else
      state <= state_next;
  end

  // Data is held for the whole OFFER phase
  always_ff @(posedge CLK_50M)
  begin
    if (capture)
      sample_data <= sample;
  end

  assign sample_req = (state == OFFER);

endmodule

`default_nettype wire

//--- src/tone_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tone_gen import organ_pkg::*; #(
  parameter int CLK_HZ = 50_000_000
) (
  input  wire logic      CLK_50M,
  input  wire logic      arst_n,
  input  wire note_sel_t note_sel,
  input  wire logic      tone_on,
  output sample_t        sample
);

  localparam int NUM_NOTES = 2 ** $bits(note_sel_t);

  half_period_t half_table [NUM_NOTES];
  half_period_t half_cnt;
  half_period_t half_last;
  note_sel_t    note_q;
  logic         wave;

  // ==========================================================
  // Half period per note, fixed at elaboration
  // ==========================================================
  for (genvar i = 0; i < NUM_NOTES; i++)
  begin : g_half
    localparam int unsigned HALF = CLK_HZ / (2 * NOTE_FREQ_HZ[i]);
    assign half_table[i] = half_period_t'(HALF);
  end

  assign half_last = half_table[note_sel] - 1'b1;

  // ==========================================================
  // Square wave
  // ==========================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      note_q   <= '0;
      half_cnt <= '0;
      wave     <= 1'b0;
    end
    else
    begin
      note_q <= note_sel;
      // New note starts a fresh half period
      if (note_sel != note_q)
      begin
        half_cnt <= '0;
      end
      else if (half_cnt == half_last)
      begin
        half_cnt <= '0;
        wave     <= ~wave;
      end
      else
      begin
        half_cnt <= half_cnt + 1'b1;
      end
    end
  end

  // Muted output is mid-scale zero
  always_comb
  begin
    if (!tone_on)
      sample = '0;
    else
      sample = wave ? SAMPLE_HIGH : SAMPLE_LOW;
  end

endmodule

`default_nettype wire

//--- src/hex_display.sv
`timescale 1ns/1ps
`default_nettype none

module hex_display import organ_pkg::*; #(
  parameter int DISPLAY_REFRESH = 25_000_000
) (
  input  wire logic   CLK_50M,
  input  wire logic   arst_n,
  input  wire count_t count,
  output seg_t        hex0,
  output seg_t        hex1,
  output seg_t        hex2,
  output seg_t        hex3
);

  localparam int REF_W = (DISPLAY_REFRESH > 1) ? $clog2(DISPLAY_REFRESH) : 1;
  localparam logic [REF_W-1:0] REF_LAST = REF_W'(DISPLAY_REFRESH - 1);

  logic [REF_W-1:0] refresh_cnt;
  logic             refresh_hit;
  count_t           shown;
  nibble_t          digit [4];

  // ==========================================================
  // Refresh counter and count latch
  // ==========================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      refresh_cnt <= '0;
    end
    else if (refresh_cnt == REF_LAST)
    begin
      refresh_cnt <= '0;
    end
    else
    begin
      refresh_cnt <= refresh_cnt + 1'b1;
    end
  end

  // Latch at the start of each refresh interval
  assign refresh_hit = (refresh_cnt == '0);

  always_ff @(posedge CLK_50M)
  begin
    if (refresh_hit)
    begin
      shown <= count;
    end
  end

  // ==========================================================
  // Nibble split and segment registers
  // ==========================================================
  always_comb
  begin
    for (int i = 0; i < 4; i++)
    begin
      digit[i] = shown[4*i +: 4];
    end
  end

  // hex0 carries the lowest nibble
  always_ff @(posedge CLK_50M)
  begin
    hex0 <= HEX_SEGMENTS[digit[0]];
    hex1 <= HEX_SEGMENTS[digit[1]];
    hex2 <= HEX_SEGMENTS[digit[2]];
    hex3 <= HEX_SEGMENTS[digit[3]];
  end

endmodule

`default_nettype wire

//--- src/speed_register.sv
`timescale 1ns/1ps
`default_nettype none

module speed_register import organ_pkg::*; #(
  parameter int SPEED_STEP    = 100,
  parameter int DEFAULT_COUNT = 12499
) (
  input  wire logic CLK_50M,
  input  wire logic arst_n,
  input  wire logic up_event,
  input  wire logic down_event,
  input  wire logic reset_level,
  output count_t    count
);

  localparam logic [16:0] STEP_EXT   = 17'(SPEED_STEP);
  localparam count_t      COUNT_INIT = count_t'(DEFAULT_COUNT);

  logic [16:0] sum_up;
  logic [16:0] diff_down;
  logic        can_up;
  logic        can_down;

  // ==========================================================
  // Saturation limits
  // ==========================================================
  // Extra bit catches the carry out of count_t
  assign sum_up    = {1'b0, count} + STEP_EXT;
  assign diff_down = {1'b0, count} - STEP_EXT;

  assign can_up   = ~sum_up[16];
  // Floor is SPEED_STEP, not zero
  assign can_down = ~diff_down[16] && (diff_down[15:0] >= STEP_EXT[15:0]);

  // ==========================================================
  // Count register
  // ==========================================================
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      count <= COUNT_INIT;
    end
    else if (reset_level)
    begin
      count <= COUNT_INIT;
    end
    else if (up_event && !down_event && can_up)
    begin
      count <= count_t'(sum_up);
    end
    else if (down_event && !up_event && can_down)
    begin
      count <= count_t'(diff_down);
    end
  end

endmodule

`default_nettype wire

//--- src/key_event_gen.sv
`timescale 1ns/1ps
`default_nettype none

module key_event_gen #(
  parameter int EVENT_INTERVAL = 100_000
) (
  input  wire logic CLK_50M,
  input  wire logic arst_n,
  input  wire logic key_up_n,
  input  wire logic key_down_n,
  input  wire logic key_reset_n,
  output logic      up_event,
  output logic      down_event,
  output logic      reset_level
);

  localparam int CNT_W = (EVENT_INTERVAL > 1) ? $clog2(EVENT_INTERVAL) : 1;
  localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(EVENT_INTERVAL - 1);

  // Bit positions inside the key vectors
  localparam int KEY_UP    = 0;
  localparam int KEY_DOWN  = 1;
  localparam int KEY_RESET = 2;

  logic [2:0]       key_raw;
  logic [2:0]       key_meta;
  logic [2:0]       key_sync;
  logic [CNT_W-1:0] interval_cnt;
  logic             interval_wrap;

  // ==========================================================
  // Key synchronizers
  // ==========================================================
  // Keys are active low on the board
  assign key_raw = ~{key_reset_n, key_down_n, key_up_n};

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      key_meta <= '0;
      key_sync <= '0;
    end
    else
    begin
      key_meta <= key_raw;
      key_sync <= key_meta;
    end
  end

  // ==========================================================
  // Event interval and pulses
  // ==========================================================
  assign interval_wrap = (interval_cnt == CNT_LAST);

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      interval_cnt <= '0;
      up_event     <= 1'b0;
      down_event   <= 1'b0;
    end
    else
    begin
      interval_cnt <= interval_wrap ? '0 : interval_cnt + 1'b1;
      // One pulse per interval for each held key
      up_event     <= interval_wrap & key_sync[KEY_UP];
      down_event   <= interval_wrap & key_sync[KEY_DOWN];
    end
  end

  assign reset_level = key_sync[KEY_RESET];

endmodule

`default_nettype wire

//--- src/organ_pkg.sv
`default_nettype none

package organ_pkg;

  // ==========================================================
  // Widths with a meaning
  // ==========================================================
  typedef logic [2:0]         note_sel_t;
  typedef logic [23:0]        half_period_t;
  typedef logic signed [7:0]  sample_t;
  typedef logic [15:0]        count_t;
  typedef logic [3:0]         nibble_t;
  // Active low with bit 0 driving segment a
  typedef logic [6:0]         seg_t;

  typedef enum logic [1:0]
  {
    IDLE,
    OFFER,
    RELEASE
  } port_state_t;

  // ==========================================================
  // Tables
  // ==========================================================
  // C major scale from C4 up to C5
  localparam int unsigned NOTE_FREQ_HZ [0:7] = '{262, 294, 330, 349, 392, 440, 494, 523};

  localparam seg_t HEX_SEGMENTS [0:15] = '{
    7'h40, 7'h79, 7'h24, 7'h30,
    7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03,
    7'h46, 7'h21, 7'h06, 7'h0E
  };

  // Square wave levels at full positive and negative swing
  localparam sample_t SAMPLE_HIGH = 8'sh7F;
  localparam sample_t SAMPLE_LOW  = 8'sh80;

endpackage

`default_nettype wire
